// ==== Makefile ====
.PHONY: build run clean

build:
	verilator --binary --timing --assert -f vlog.f --top-module siThresholdTb \
		-Mdir obj_dir -o simv

run: build
	./obj_dir/simv > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== common/siPkg.sv ====
`default_nettype none

package siPkg;

    // sample and bin geometry
    localparam int PixelW   = 12;
    localparam int BinW     = 4;
    localparam int BinShift = PixelW - BinW;   // pixel bits below the bin index

    typedef logic [PixelW-1:0] pixel_t;
    typedef logic [BinW-1:0]   bin_t;

    // three quarters of one bin, half the window width
    localparam pixel_t HalfSpan = pixel_t'(3 << (BinShift - 2));

    // one input sample, single-cycle valid strobe
    typedef struct packed {
        logic   valid;
        logic   last;    // final sample of the frame
        pixel_t pixel;
    } sample_t;

    // threshold window derived from the peak bin
    typedef struct packed {
        bin_t   peakBin;
        pixel_t lower;
        pixel_t upper;
    } window_t;

    typedef enum logic [1:0] {
        regionBelow,
        regionInside,
        regionAbove
    } region_t;

    // classification of one sample
    typedef struct packed {
        logic    valid;
        pixel_t  pixel;
        region_t region;
        pixel_t  offset;   // distance above lower, inside only
    } result_t;

endpackage

`default_nettype wire

// ==== hdl/frameControl.sv ====
`default_nettype none

module frameControl (
    input  wire logic   peakDone,
    input  wire logic   rstN,
    input  wire logic   sampleValid,
    input  wire logic   sampleLast,
    output logic        countEn,
    output logic        scanActive,
    output logic        peakStrobe,
    output siPkg::bin_t scanIdx
);

    typedef enum logic {
        phaseAccum,
        phaseScan
    } phase_t;

    localparam siPkg::bin_t LastIdx = '1;

    phase_t phase;

    assign scanActive = (phase == phaseScan);
    assign countEn    = sampleValid && (phase == phaseAccum);   // scan-time samples are dropped

    always_ff @(posedge peakDone or negedge rstN) begin
        if (!rstN) begin
            phase      <= phaseAccum;
            scanIdx    <= '0;
            peakStrobe <= 1'b0;
        end else begin
            peakStrobe <= 1'b0;
            case (phase)
                phaseAccum: begin
                    if (sampleValid && sampleLast) begin
                        phase <= phaseScan;   // index already sits at 0
                    end
                end
                phaseScan: begin
                    scanIdx <= scanIdx + siPkg::bin_t'(1);   // wraps back to 0 after the last bin
                    if (scanIdx == LastIdx) begin
                        phase      <= phaseAccum;
                        peakStrobe <= 1'b1;   // peak is final next cycle
                    end
                end
                default: begin
                    phase <= phaseAccum;
                end
            endcase
        end
    end

    // index only moves while scanning, including the wrap on exit
    scanIdxStable: assert property (
        @(posedge peakDone) disable iff (!rstN)
        !scanActive |=> $stable(scanIdx)
    ) else $error("scan index moved outside a scan");

    peakStrobeSingle: assert property (
        @(posedge peakDone) disable iff (!rstN)
        peakStrobe |=> !peakStrobe
    ) else $error("peak strobe held for two cycles");

    // every scan lasts exactly one pass over the bins
    scanLength: assert property (
        @(posedge peakDone) disable iff (!rstN)
        $rose(scanActive) |-> scanActive [*16] ##1 (!scanActive && peakStrobe)
    ) else $error("scan did not finish after sixteen bins");

endmodule

`default_nettype wire

// ==== hdl/pixelClassifier.sv ====
`default_nettype none

module pixelClassifier (
    input  wire logic           peakDone,
    input  wire logic           rstN,
    input  wire siPkg::sample_t sample,
    input  wire siPkg::window_t window,
    output siPkg::result_t      result
);

    siPkg::region_t region;
    siPkg::pixel_t  offset;
    siPkg::region_t regionQ;
    siPkg::pixel_t  pixelQ;
    siPkg::pixel_t  offsetQ;
    logic           validQ;

    // bounds themselves count as inside
    always_comb begin
        offset = '0;
        if (sample.pixel < window.lower) begin
            region = siPkg::regionBelow;
        end else if (sample.pixel > window.upper) begin
            region = siPkg::regionAbove;
        end else begin
            region = siPkg::regionInside;
            offset = sample.pixel - window.lower;
        end
    end

    always_ff @(posedge peakDone or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= sample.valid;
        end
    end

    always_ff @(posedge peakDone) begin
        if (sample.valid) begin
            pixelQ  <= sample.pixel;
            regionQ <= region;
            offsetQ <= offset;
        end
    end

    assign result.valid  = validQ;
    assign result.pixel  = pixelQ;
    assign result.region = regionQ;
    assign result.offset = offsetQ;

endmodule

`default_nettype wire

// ==== hdl/siThresholdTop.sv ====
`default_nettype none

module siThresholdTop #(
    parameter int CountW = 10   // per-bin counter width
) (
    input  wire logic           peakDone,
    input  wire logic           rstN,
    input  wire siPkg::sample_t sampleIn,
    output siPkg::window_t      windowOut,
    output logic                windowValid,
    output siPkg::result_t      resultOut
);

    logic        countEn;
    logic        scanActive;
    logic        peakStrobe;
    siPkg::bin_t scanIdx;
    siPkg::bin_t peakBin;

    frameControl uFrameControl (
        .peakDone    (peakDone),
        .rstN        (rstN),
        .sampleValid (sampleIn.valid),
        .sampleLast  (sampleIn.last),
        .countEn     (countEn),
        .scanActive  (scanActive),
        .peakStrobe  (peakStrobe),
        .scanIdx     (scanIdx)
    );

    binHistogram #(
        .CountW (CountW)
    ) uBinHistogram (
        .peakDone   (peakDone),
        .rstN       (rstN),
        .pixel      (sampleIn.pixel),
        .countEn    (countEn),
        .scanActive (scanActive),
        .scanIdx    (scanIdx),
        .peakBin    (peakBin)
    );

    peakWindow uPeakWindow (
        .peakDone    (peakDone),
        .rstN        (rstN),
        .peakBin     (peakBin),
        .peakStrobe  (peakStrobe),
        .window      (windowOut),
        .windowValid (windowValid)
    );

    // classifies against the window of the previous frame
    pixelClassifier uPixelClassifier (
        .peakDone (peakDone),
        .rstN     (rstN),
        .sample   (sampleIn),
        .window   (windowOut),
        .result   (resultOut)
    );

endmodule

`default_nettype wire

// ==== tb/siThresholdTb.sv ====
`default_nettype none

module siThresholdTb;

    localparam int CountW      = 10;
    localparam int StimDepth   = 256;
    localparam int IdleCycles  = 18;
    localparam int WindowDelay = 18;   // posedges from the last sample drive to the visible pulse

    logic           peakDone;
    logic           rstN;
    siPkg::sample_t sampleIn;
    siPkg::window_t windowOut;
    logic           windowValid;
    siPkg::result_t resultOut;

    logic [15:0]    stim [StimDepth];
    siPkg::window_t heldWindow;   // model of the window the DUT holds
    siPkg::result_t resultQ [$];
    string          resultNameQ [$];
    siPkg::window_t windowQ [$];
    string          windowNameQ [$];
    int             lastDrive;
    int             cycles;
    int             limit;
    int             windowErrors;
    int             resultErrors;
    int             otherErrors;

    siThresholdTop #(
        .CountW (CountW)
    ) UUT (
        .peakDone    (peakDone),
        .rstN        (rstN),
        .sampleIn    (sampleIn),
        .windowOut   (windowOut),
        .windowValid (windowValid),
        .resultOut   (resultOut)
    );

    always #4 peakDone = ~peakDone;

    always @(posedge peakDone) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the run went past %0d cycles", limit);
            $display("sim failed");
            $finish;
        end
    end

    // region rule: bounds count as inside, offset measured from lower
    function automatic siPkg::result_t expectedResult(input siPkg::pixel_t pix,
                                                      input siPkg::window_t win);
        siPkg::result_t res;
        res.valid  = 1'b1;
        res.pixel  = pix;
        res.offset = '0;
        if (pix < win.lower) begin
            res.region = siPkg::regionBelow;
        end else if (pix > win.upper) begin
            res.region = siPkg::regionAbove;
        end else begin
            res.region = siPkg::regionInside;
            res.offset = pix - win.lower;
        end
        return res;
    endfunction

    task automatic checkWindow(input string name, input siPkg::window_t expWin,
                               input siPkg::window_t actWin);
        if (actWin !== expWin) begin
            windowErrors++;
            $display("error %s: peakBin/lower/upper expected %0d/%h/%h, actual %0d/%h/%h",
                     name, expWin.peakBin, expWin.lower, expWin.upper,
                     actWin.peakBin, actWin.lower, actWin.upper);
        end
    endtask

    task automatic checkResult(input string name, input siPkg::result_t expRes,
                               input siPkg::result_t actRes);
        if (actRes !== expRes) begin
            resultErrors++;
            $display("error %s: pixel/region/offset expected %h/%0d/%h, actual %h/%0d/%h",
                     name, expRes.pixel, expRes.region, expRes.offset,
                     actRes.pixel, actRes.region, actRes.offset);
        end
    endtask

    // outputs are read on the falling edge, half a cycle after they settle
    task automatic watchOutputs();
        if (resultOut.valid) begin
            if (resultQ.size() == 0) begin
                otherErrors++;
                $display("a result came out with no sample waiting for it");
            end else begin
                checkResult(resultNameQ.pop_front(), resultQ.pop_front(), resultOut);
            end
        end
        if (windowValid) begin
            if (windowQ.size() == 0) begin
                otherErrors++;
                $display("windowValid pulsed although no frame had finished");
            end else begin
                if (cycles - lastDrive != WindowDelay) begin
                    otherErrors++;
                    $display("window pulse came %0d cycles after the last sample instead of %0d",
                             cycles - lastDrive, WindowDelay);
                end
                heldWindow = windowQ.pop_front();   // new window for the samples that follow
                checkWindow(windowNameQ.pop_front(), heldWindow, windowOut);
            end
        end
    endtask

    task automatic driveSample(input string name, input siPkg::pixel_t pix, input logic last);
        @(negedge peakDone);
        watchOutputs();
        sampleIn.valid = 1'b1;
        sampleIn.last  = last;
        sampleIn.pixel = pix;
        resultQ.push_back(expectedResult(pix, heldWindow));
        resultNameQ.push_back(name);
        if (last) begin
            lastDrive = cycles;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge peakDone);
            watchOutputs();
            sampleIn = '0;
        end
    endtask

    initial begin : stimulus
        int             ptr;
        int             frames;
        int             count;
        int             totalSamples;
        siPkg::window_t fileWin;
        peakDone     = 1'b0;
        rstN         = 1'b0;
        sampleIn     = '0;
        cycles       = 0;
        lastDrive    = 0;
        windowErrors = 0;
        resultErrors = 0;
        otherErrors  = 0;
        heldWindow.peakBin = '0;
        heldWindow.lower   = '0;
        heldWindow.upper   = '1;   // reset window, everything inside
        for (int i = 0; i < StimDepth; i++) begin
            stim[i] = '0;   // a zero count ends the list
        end
        $readmemh("tb/thresholdStim.txt", stim);

        // size the timeout from the records
        ptr          = 0;
        frames       = 0;
        totalSamples = 0;
        while (ptr < StimDepth && stim[ptr] != '0) begin
            totalSamples += int'(stim[ptr]);
            ptr          += int'(stim[ptr]) + 4;
            frames++;
        end
        limit = 5 + totalSamples + 20 * frames + 50;

        repeat (5) @(negedge peakDone);
        rstN = 1'b1;
        checkWindow("reset window", heldWindow, windowOut);

        ptr = 0;
        for (int f = 0; f < frames; f++) begin
            count = int'(stim[ptr]);
            for (int s = 0; s < count; s++) begin
                driveSample($sformatf("frame %0d sample %0d", f, s), stim[ptr + 1 + s][11:0],
                            s == count - 1);
            end
            ptr += count + 1;
            fileWin.peakBin = stim[ptr][3:0];
            fileWin.lower   = stim[ptr + 1][11:0];
            fileWin.upper   = stim[ptr + 2][11:0];
            windowQ.push_back(fileWin);
            windowNameQ.push_back($sformatf("frame %0d window", f));
            ptr += 3;
            idle(IdleCycles);
        end
        idle(2);   // a little slack after the last frame

        if (resultQ.size() != 0) begin
            otherErrors++;
            $display("%0d results never came out", resultQ.size());
        end
        if (windowQ.size() != 0) begin
            otherErrors++;
            $display("%0d window pulses never came", windowQ.size());
        end
        $display("errors: window %0d, result %0d, other %0d",
                 windowErrors, resultErrors, otherErrors);
        if (windowErrors + resultErrors + otherErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/thresholdStim.txt ====
// record: sample count, that many pixels, then expected peakBin, lower, upper
// all values hex, a zero count ends the list
// frame 0: clear peak in bin 7, classified against the reset window
5
700 7ff 750 123 abc
7 640 7c0
// frame 1: bins 0, 1, 6 and 7 tie, bin 0 wins and clamps at zero
8
010 1a0 0ff 1c0 640 7c0 63f 7c1
0 000 180
// frame 2: peak in bin 15, pixels at the bounds of the clamped window
7
f00 fff f80 e10 180 181 000
f e40 fc0
// frame 3: bins 3, 9 and 15 tie after clearing, bin 3 wins
7
300 9ab 3ff 900 f10 fc1 e40
3 240 3c0
// frame 4: bins 2 and 3 tie, pixels on both sides of each bound
5
240 3c0 23f 3c1 800
2 140 2c0
0

// ==== threshold/binHistogram.sv ====
`default_nettype none

module binHistogram #(
    parameter int CountW = 10
) (
    input  wire logic          peakDone,
    input  wire logic          rstN,
    input  wire siPkg::pixel_t pixel,
    input  wire logic          countEn,
    input  wire logic          scanActive,
    input  wire siPkg::bin_t   scanIdx,
    output siPkg::bin_t        peakBin
);

    localparam int NumBins = 2 ** siPkg::BinW;

    logic [CountW-1:0] binCount [NumBins];
    logic [CountW-1:0] maxCount;        // running maximum of the scan
    logic [CountW-1:0] scanCount;
    siPkg::bin_t       binSel;

    assign binSel    = pixel[siPkg::PixelW-1 -: siPkg::BinW];   // top bits name the bin
    assign scanCount = binCount[scanIdx];

    // counting outside a scan, read-and-clear inside it
    always_ff @(posedge peakDone or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NumBins; i++) begin
                binCount[i] <= '0;
            end
        end else if (scanActive) begin
            binCount[scanIdx] <= '0;
        end else if (countEn) begin
            binCount[binSel] <= binCount[binSel] + CountW'(1);
        end
    end

    // peak search
    // strictly greater replaces, so ties keep the lower index
    always_ff @(posedge peakDone or negedge rstN) begin
        if (!rstN) begin
            maxCount <= '0;
            peakBin  <= '0;
        end else if (scanActive) begin
            if (scanIdx == '0 || scanCount > maxCount) begin   // first bin restarts the search
                maxCount <= scanCount;
                peakBin  <= scanIdx;
            end
        end
    end

    // a full counter would wrap and corrupt the peak
    countNoWrap: assert property (
        @(posedge peakDone) disable iff (!rstN)
        countEn && !scanActive |-> binCount[binSel] != '1
    ) else $error("histogram counter overflow on bin %0d", binSel);

endmodule

`default_nettype wire

// ==== threshold/peakWindow.sv ====
`default_nettype none

module peakWindow (
    input  wire logic        peakDone,
    input  wire logic        rstN,
    input  wire siPkg::bin_t peakBin,
    input  wire logic        peakStrobe,
    output siPkg::window_t   window,
    output logic             windowValid
);

    localparam siPkg::pixel_t MaxPixel = '1;
    localparam siPkg::pixel_t FullSpan = siPkg::HalfSpan << 1;

    siPkg::pixel_t  centre;
    siPkg::window_t nextWindow;

    // centre on the bin start, then clamp against both ends
    always_comb begin
        centre = {peakBin, {siPkg::BinShift{1'b0}}};
        nextWindow.peakBin = peakBin;
        if (centre <= siPkg::HalfSpan) begin
            nextWindow.lower = '0;                   // pinned at zero
            nextWindow.upper = FullSpan;
        end else if (centre >= MaxPixel - siPkg::HalfSpan) begin
            nextWindow.lower = MaxPixel - FullSpan;  // pinned at full scale
            nextWindow.upper = MaxPixel;
        end else begin
            nextWindow.lower = centre - siPkg::HalfSpan;
            nextWindow.upper = centre + siPkg::HalfSpan;
        end
    end

    // window held until the next peak strobe
    always_ff @(posedge peakDone or negedge rstN) begin
        if (!rstN) begin
            window.peakBin <= '0;
            window.lower   <= '0;
            window.upper   <= MaxPixel;   // everything inside before the first frame
            windowValid    <= 1'b0;
        end else begin
            windowValid <= peakStrobe;
            if (peakStrobe) begin
                window <= nextWindow;
            end
        end
    end

    windowOrdered: assert property (
        @(posedge peakDone) disable iff (!rstN)
        window.lower <= window.upper
    ) else $error("window lower %0d above upper %0d", window.lower, window.upper);

endmodule

`default_nettype wire

// ==== vlog.f ====
common/siPkg.sv
hdl/frameControl.sv
threshold/binHistogram.sv
threshold/peakWindow.sv
hdl/pixelClassifier.sv
hdl/siThresholdTop.sv
tb/siThresholdTb.sv
